// File: rtl/fma_pkg.sv
package fma_pkg;

  // ------------------------------------------------
  // Binary16 format and internal widths
  // ------------------------------------------------
  localparam int EXP_BITS = 5;
  localparam int MAN_BITS = 10;
  localparam int BIAS = 15;
  // Precision including the implicit bit
  localparam int PREC_BITS = MAN_BITS + 1;
  // Internal mantissa is 3p+4 bits wide, guard and round included
  localparam int SUM_WIDTH = 3 * PREC_BITS + 4;
  // Lower 2p+3 bits are searched for leading zeros
  localparam int LOWER_SUM_WIDTH = 2 * PREC_BITS + 3;
  localparam int EXP_WIDTH = EXP_BITS + 2;
  localparam int SHAMT_WIDTH = 6;
  localparam int TAG_WIDTH = 4;
  // Canonical quiet NaN
  localparam logic [15:0] QNAN = 16'h7E00;

  // ------------------------------------------------
  // Types
  // ------------------------------------------------
  typedef struct packed {
    logic                sign;
    logic [EXP_BITS-1:0] exponent;
    logic [MAN_BITS-1:0] mantissa;
  } fp16_t;

  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_info_t;

  // IEEE exception flags
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  typedef enum logic [1:0] {
    OP_FMADD,
    OP_FNMSUB,
    OP_ADD,
    OP_MUL
  } fma_op_e;

  typedef struct packed {
    fp16_t                operand_a;
    fp16_t                operand_b;
    fp16_t                operand_c;
    fma_op_e              op;
    logic                 op_mod;
    logic [TAG_WIDTH-1:0] tag;
  } fma_req_t;

  // Adjusted operands with special case outcome
  typedef struct packed {
    fp16_t                operand_a;
    fp16_t                operand_b;
    fp16_t                operand_c;
    fp_info_t             info_a;
    fp_info_t             info_b;
    fp_info_t             info_c;
    logic                 is_special;
    fp16_t                special_result;
    status_t              special_status;
    logic [TAG_WIDTH-1:0] tag;
  } prep_t;

  // Bundle carried by the pipeline stages
  typedef struct packed {
    logic                        eff_sub;
    logic signed [EXP_WIDTH-1:0] exp_prod;
    logic signed [EXP_WIDTH-1:0] exp_diff;
    logic signed [EXP_WIDTH-1:0] tent_exp;
    logic [SHAMT_WIDTH-1:0]      addend_shamt;
    logic                        sticky;
    logic [SUM_WIDTH-1:0]        sum;
    logic                        final_sign;
    logic                        is_special;
    fp16_t                       special_result;
    status_t                     special_status;
    logic [TAG_WIDTH-1:0]        tag;
  } mid_t;

  typedef struct packed {
    fp16_t                result;
    status_t              status;
    logic [TAG_WIDTH-1:0] tag;
  } fma_rsp_t;

endpackage

// File: rtl/fma_classify_select.sv
`timescale 1ns/1ps

module fma_classify_select
  import fma_pkg::*;
(
  input  fma_req_t req_i,
  output prep_t    prep_o
);

  // Field-based operand classification
  function automatic fp_info_t classify(input fp16_t x);
    fp_info_t info;
    logic     exp_zero;
    logic     exp_ones;
    logic     man_zero;
    exp_zero           = (x.exponent == '0);
    exp_ones           = (x.exponent == '1);
    man_zero           = (x.mantissa == '0);
    info.is_normal     = !exp_zero && !exp_ones;
    info.is_subnormal  = exp_zero && !man_zero;
    info.is_zero       = exp_zero && man_zero;
    info.is_inf        = exp_ones && man_zero;
    info.is_nan        = exp_ones && !man_zero;
    // Quiet bit is the mantissa MSB
    info.is_signalling = info.is_nan && !x.mantissa[MAN_BITS-1];
    return info;
  endfunction

  fp16_t    op_a, op_b, op_c;
  fp_info_t info_a, info_b, info_c;
  logic     any_inf, any_nan, any_snan;
  logic     eff_sub;
  logic     prod_inf;

  // ------------------------------------------------
  // Operation select
  // ------------------------------------------------
  always_comb begin
    op_a   = req_i.operand_a;
    op_b   = req_i.operand_b;
    op_c   = req_i.operand_c;
    info_a = classify(req_i.operand_a);
    info_b = classify(req_i.operand_b);
    info_c = classify(req_i.operand_c);
    // Sign modifier always flips the addend
    op_c.sign = op_c.sign ^ req_i.op_mod;
    unique case (req_i.op)
      OP_FMADD: ;
      // Negated product
      OP_FNMSUB: op_a.sign = ~op_a.sign;
      // Multiplicand forced to +1.0
      OP_ADD: begin
        op_a   = '{sign: 1'b0, exponent: EXP_BITS'(BIAS), mantissa: '0};
        info_a = '{is_normal: 1'b1, default: 1'b0};
      end
      // Addend forced to -0, so a zero product keeps its sign
      OP_MUL: begin
        op_c   = '{sign: 1'b1, exponent: '0, mantissa: '0};
        info_c = '{is_zero: 1'b1, default: 1'b0};
      end
    endcase
  end

  assign any_inf  = info_a.is_inf | info_b.is_inf | info_c.is_inf;
  assign any_nan  = info_a.is_nan | info_b.is_nan | info_c.is_nan;
  assign any_snan = info_a.is_signalling | info_b.is_signalling | info_c.is_signalling;
  assign eff_sub  = op_a.sign ^ op_b.sign ^ op_c.sign;
  assign prod_inf = info_a.is_inf | info_b.is_inf;

  // ------------------------------------------------
  // Special cases, highest priority first
  // ------------------------------------------------
  always_comb begin
    prep_o.operand_a      = op_a;
    prep_o.operand_b      = op_b;
    prep_o.operand_c      = op_c;
    prep_o.info_a         = info_a;
    prep_o.info_b         = info_b;
    prep_o.info_c         = info_c;
    prep_o.tag            = req_i.tag;
    prep_o.special_result = QNAN;
    prep_o.special_status = '0;
    prep_o.is_special     = 1'b0;
    // Inf times zero is invalid even with a quiet NaN addend
    if ((info_a.is_inf && info_b.is_zero) || (info_a.is_zero && info_b.is_inf)) begin
      prep_o.is_special        = 1'b1;
      prep_o.special_status.nv = 1'b1;
    end else if (any_nan) begin
      prep_o.is_special        = 1'b1;
      prep_o.special_status.nv = any_snan;
    end else if (any_inf) begin
      prep_o.is_special = 1'b1;
      if (prod_inf && info_c.is_inf && eff_sub) begin
        // Opposite infinities cancel
        prep_o.special_status.nv = 1'b1;
      end else if (prod_inf) begin
        prep_o.special_result = '{sign: op_a.sign ^ op_b.sign, exponent: '1, mantissa: '0};
      end else begin
        prep_o.special_result = '{sign: op_c.sign, exponent: '1, mantissa: '0};
      end
    end
  end

endmodule

// File: rtl/fma_align_add.sv
`timescale 1ns/1ps

module fma_align_add
  import fma_pkg::*;
(
  input  prep_t prep_i,
  output mid_t  mid_o
);

  logic signed [EXP_WIDTH-1:0] exp_a, exp_b, exp_c;
  logic signed [EXP_WIDTH-1:0] exp_addend, exp_prod, exp_diff, tent_exp;
  logic [SHAMT_WIDTH-1:0]      addend_shamt;
  logic [PREC_BITS-1:0]        man_a, man_b, man_c;
  logic [2*PREC_BITS-1:0]      product;
  logic [SUM_WIDTH-1:0]        product_shifted;
  logic [SUM_WIDTH+PREC_BITS-1:0] addend_wide;
  logic [SUM_WIDTH-1:0]        addend_shifted;
  logic                        sticky;
  logic                        eff_sub, tent_sign;
  logic [SUM_WIDTH:0]          sum_raw;

  // ------------------------------------------------
  // Exponent path
  // ------------------------------------------------
  assign exp_a = signed'({2'b00, prep_i.operand_a.exponent});
  assign exp_b = signed'({2'b00, prep_i.operand_b.exponent});
  assign exp_c = signed'({2'b00, prep_i.operand_c.exponent});

  // Subnormals behave as encoded exponent 1
  assign exp_addend = exp_c + EXP_WIDTH'(!prep_i.info_c.is_normal);
  // Zero product gets the smallest exponent
  assign exp_prod = (prep_i.info_a.is_zero || prep_i.info_b.is_zero) ? EXP_WIDTH'(2 - BIAS) :
                    exp_a + EXP_WIDTH'(prep_i.info_a.is_subnormal) +
                    exp_b + EXP_WIDTH'(prep_i.info_b.is_subnormal) - EXP_WIDTH'(BIAS);
  assign exp_diff = exp_addend - exp_prod;
  assign tent_exp = (exp_diff > 0) ? exp_addend : exp_prod;

  // Right shift of the addend, saturating on both ends
  always_comb begin
    if (exp_diff <= -2 * PREC_BITS - 1) begin
      addend_shamt = SHAMT_WIDTH'(3 * PREC_BITS + 4);
    end else if (exp_diff <= PREC_BITS + 2) begin
      addend_shamt = SHAMT_WIDTH'(PREC_BITS + 3 - exp_diff);
    end else begin
      addend_shamt = '0;
    end
  end

  // ------------------------------------------------
  // Mantissa product and aligned addend
  // ------------------------------------------------
  assign man_a = {prep_i.info_a.is_normal, prep_i.operand_a.mantissa};
  assign man_b = {prep_i.info_b.is_normal, prep_i.operand_b.mantissa};
  assign man_c = {prep_i.info_c.is_normal, prep_i.operand_c.mantissa};

  assign product = man_a * man_b;
  // Two low bits left free for round and sticky
  assign product_shifted = SUM_WIDTH'(product) << 2;

  // Bits pushed below the sum window fold into sticky
  assign addend_wide = {man_c, {SUM_WIDTH{1'b0}}} >> addend_shamt;
  assign sticky      = |addend_wide[PREC_BITS-1:0];

  assign eff_sub   = prep_i.operand_a.sign ^ prep_i.operand_b.sign ^ prep_i.operand_c.sign;
  assign tent_sign = prep_i.operand_a.sign ^ prep_i.operand_b.sign;

  assign addend_shifted = eff_sub ? ~addend_wide[SUM_WIDTH+PREC_BITS-1:PREC_BITS] :
                                    addend_wide[SUM_WIDTH+PREC_BITS-1:PREC_BITS];
  // Carry-in completes the two's complement only if nothing was lost
  assign sum_raw = product_shifted + addend_shifted + SUM_WIDTH'(eff_sub & ~sticky);

  // ------------------------------------------------
  // Output bundle
  // ------------------------------------------------
  always_comb begin
    mid_o.eff_sub      = eff_sub;
    mid_o.exp_prod     = exp_prod;
    mid_o.exp_diff     = exp_diff;
    mid_o.tent_exp     = tent_exp;
    mid_o.addend_shamt = addend_shamt;
    mid_o.sticky       = sticky;
    // No carry under subtraction means a negative sum
    mid_o.sum = (eff_sub && !sum_raw[SUM_WIDTH]) ? SUM_WIDTH'(-sum_raw) :
                                                   sum_raw[SUM_WIDTH-1:0];
    // Sign flips when the subtraction result was mispredicted
    mid_o.final_sign     = eff_sub ? (sum_raw[SUM_WIDTH] == tent_sign) : tent_sign;
    mid_o.is_special     = prep_i.is_special;
    mid_o.special_result = prep_i.special_result;
    mid_o.special_status = prep_i.special_status;
    mid_o.tag            = prep_i.tag;
  end

endmodule

// File: rtl/fma_pipe_stage.sv
`timescale 1ns/1ps

module fma_pipe_stage
  import fma_pkg::*;
(
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic flush_i,
  input  logic valid_i,
  output logic ready_o,
  input  mid_t data_i,
  output logic valid_o,
  input  logic ready_i,
  output mid_t data_o
);

  logic valid_q;
  mid_t data_q;

  // Free slot or downstream draining this cycle
  assign ready_o = ~valid_q | ready_i;

  // Flush wins over a new load
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= 1'b0;
    end else if (flush_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Payload only moves on an accepted item
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

// File: rtl/fma_normalize_round.sv
`timescale 1ns/1ps

module fma_normalize_round
  import fma_pkg::*;
(
  input  mid_t     mid_i,
  output fma_rsp_t rsp_o
);

  logic signed [EXP_WIDTH-1:0] exp_prod, exp_diff;
  logic [LOWER_SUM_WIDTH-1:0]  sum_lower;
  logic [SHAMT_WIDTH-1:0]      lz_cnt;
  logic signed [EXP_WIDTH-1:0] lz_sgn;
  logic                        lz_empty;
  logic [SHAMT_WIDTH-1:0]      norm_shamt;
  logic signed [EXP_WIDTH-1:0] norm_exp, final_exp;
  logic [SUM_WIDTH:0]          sum_shifted;
  logic [PREC_BITS:0]          final_man;
  logic [2*PREC_BITS+2:0]      sticky_bits;
  logic                        sticky_after;
  logic                        of_before, of_after;
  logic [EXP_BITS-1:0]         pre_exp;
  logic [MAN_BITS-1:0]         pre_man;
  logic [EXP_BITS+MAN_BITS-1:0] pre_abs, rounded_abs;
  logic [1:0]                  round_sticky;
  logic                        round_up, exact_zero;
  fp16_t                       regular_result;
  status_t                     regular_status;

  assign exp_prod  = mid_i.exp_prod;
  assign exp_diff  = mid_i.exp_diff;
  assign sum_lower = mid_i.sum[LOWER_SUM_WIDTH-1:0];

  // ------------------------------------------------
  // Leading zero count
  // ------------------------------------------------
  // Highest set bit wins as the loop runs upward
  always_comb begin
    lz_cnt = SHAMT_WIDTH'(LOWER_SUM_WIDTH);
    for (int i = 0; i < LOWER_SUM_WIDTH; i++) begin
      if (sum_lower[i]) lz_cnt = SHAMT_WIDTH'(LOWER_SUM_WIDTH - 1 - i);
    end
  end

  assign lz_empty = ~|sum_lower;
  assign lz_sgn   = signed'({1'b0, lz_cnt});

  // Shift amount from the anchoring case
  always_comb begin
    if ((exp_diff <= 0) || (mid_i.eff_sub && (exp_diff <= 2))) begin
      if ((exp_prod - lz_sgn + 1 >= 0) && !lz_empty) begin
        // Product anchored, drop the counted zeros
        norm_shamt = SHAMT_WIDTH'(PREC_BITS + 2) + lz_cnt;
        norm_exp   = exp_prod - lz_sgn + 1;
      end else begin
        // Subnormal result, shift capped at the minimum exponent
        norm_shamt = SHAMT_WIDTH'(PREC_BITS + 2 + exp_prod);
        norm_exp   = '0;
      end
    end else begin
      // Addend anchored, undo the alignment shift
      norm_shamt = mid_i.addend_shamt;
      norm_exp   = mid_i.tent_exp;
    end
  end

  assign sum_shifted = {1'b0, mid_i.sum} << norm_shamt;

  // One-bit fix-up around the sum MSB
  always_comb begin
    {final_man, sticky_bits} = sum_shifted[SUM_WIDTH-1:0];
    final_exp                = norm_exp;
    if (sum_shifted[SUM_WIDTH]) begin
      {final_man, sticky_bits} = sum_shifted[SUM_WIDTH:1];
      final_exp                = norm_exp + 1;
    end else if (sum_shifted[SUM_WIDTH-1]) begin
      final_exp = norm_exp;
    end else if (norm_exp > 1) begin
      {final_man, sticky_bits} = {sum_shifted[SUM_WIDTH-2:0], 1'b0};
      final_exp                = norm_exp - 1;
    end else begin
      final_exp = '0;
    end
  end

  assign sticky_after = (|sticky_bits) | mid_i.sticky;

  // ------------------------------------------------
  // Round to nearest even
  // ------------------------------------------------
  // All-ones exponent or above is overflow
  assign of_before = (final_exp >= (2 ** EXP_BITS) - 1);
  // Overflow is rounded up from the largest normal
  assign pre_exp = of_before ? EXP_BITS'((2 ** EXP_BITS) - 2) : final_exp[EXP_BITS-1:0];
  assign pre_man = of_before ? '1 : final_man[MAN_BITS:1];
  assign pre_abs = {pre_exp, pre_man};

  assign round_sticky = of_before ? 2'b11 : {final_man[0], sticky_after};
  assign round_up     = round_sticky[1] & (round_sticky[0] | pre_abs[0]);
  assign rounded_abs  = pre_abs + (EXP_BITS + MAN_BITS)'(round_up);
  assign of_after     = (rounded_abs[EXP_BITS+MAN_BITS-1:MAN_BITS] == '1);
  // An exact zero from a subtraction is +0
  assign exact_zero   = (rounded_abs == '0) && (round_sticky == 2'b00);

  assign regular_result.sign = (exact_zero && mid_i.eff_sub) ? 1'b0 : mid_i.final_sign;
  assign {regular_result.exponent, regular_result.mantissa} = rounded_abs;

  // ------------------------------------------------
  // Flags and result select
  // ------------------------------------------------
  assign regular_status.nv = 1'b0;
  assign regular_status.dz = 1'b0;
  assign regular_status.of = of_before | of_after;
  assign regular_status.nx = (|round_sticky) | of_before | of_after;
  assign regular_status.uf = (rounded_abs[EXP_BITS+MAN_BITS-1:MAN_BITS] == '0) &
                             regular_status.nx;

  assign rsp_o.result = mid_i.is_special ? mid_i.special_result : regular_result;
  assign rsp_o.status = mid_i.is_special ? mid_i.special_status : regular_status;
  assign rsp_o.tag    = mid_i.tag;

endmodule

// File: rtl/fma_unit.sv
`timescale 1ns/1ps

module fma_unit
  import fma_pkg::*;
#(
  parameter int unsigned NumPipeRegs = 2
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     flush_i,
  input  fma_req_t req_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  output fma_rsp_t rsp_o,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output logic     busy_o
);

  prep_t prep;
  // Index k holds the bundle after k register stages
  mid_t [0:NumPipeRegs] stage_data;
  logic [0:NumPipeRegs] stage_valid;
  // Ready is combinational through the chain
  logic [0:NumPipeRegs] stage_ready;

  // ------------------------------------------------
  // Front end
  // ------------------------------------------------
  fma_classify_select u_classify (
    .req_i  (req_i),
    .prep_o (prep)
  );

  fma_align_add u_align_add (
    .prep_i (prep),
    .mid_o  (stage_data[0])
  );

  assign stage_valid[0] = in_valid_i;
  assign in_ready_o     = stage_ready[0];

  // ------------------------------------------------
  // Register stages
  // ------------------------------------------------
  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stage
    fma_pipe_stage u_stage (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .flush_i  (flush_i),
      .valid_i  (stage_valid[i]),
      .ready_o  (stage_ready[i]),
      .data_i   (stage_data[i]),
      .valid_o  (stage_valid[i+1]),
      .ready_i  (stage_ready[i+1]),
      .data_o   (stage_data[i+1])
    );
  end

  assign stage_ready[NumPipeRegs] = out_ready_i;
  assign out_valid_o              = stage_valid[NumPipeRegs];
  // Any register holding an item
  assign busy_o = |stage_valid[1:NumPipeRegs];

  // Back end
  fma_normalize_round u_norm_round (
    .mid_i (stage_data[NumPipeRegs]),
    .rsp_o (rsp_o)
  );

endmodule

// File: tests/tb_fma_unit.sv
`timescale 1ns/1ps

module tb_fma_unit;
  import fma_pkg::*;

  localparam int NUM_REGS  = 2;
  localparam int TIMEOUT   = 200;
  localparam int BURST_LEN = 48;
  localparam logic [31:0] SEED = 32'h864033c4;

  // Status order is nv dz of uf nx
  localparam status_t ST_NONE  = 5'b00000;
  localparam status_t ST_NV    = 5'b10000;
  localparam status_t ST_NX    = 5'b00001;
  localparam status_t ST_OF_NX = 5'b00101;
  localparam status_t ST_UF_NX = 5'b00011;

  // One table row: operands, op and the exact expected response
  typedef struct packed {
    fp16_t   a;
    fp16_t   b;
    fp16_t   c;
    fma_op_e op;
    logic    op_mod;
    fp16_t   res;
    status_t st;
  } vec_t;

  logic     clk, arst_n, flush;
  logic     in_valid, in_ready, out_valid, out_ready, busy;
  fma_req_t req;
  fma_rsp_t rsp;

  // 0 holds out_ready low, 1 holds it high, 2 follows ready_rand
  logic [1:0] ready_mode;
  logic       ready_rand;

  // Scoreboard
  fma_rsp_t drive_exp;
  fma_rsp_t exp_q[$];
  fma_rsp_t exp_head = '0;
  logic     exp_have = 1'b0;
  // Items in flight after the last edge
  int       exp_count = 0;
  vec_t     exact_q[$];

  string cur_test;
  int    err_count, test_count, test_fail, errs_before, vec_count;
  bit    timed_out;

  assign out_ready = (ready_mode == 2'd2) ? ready_rand : ready_mode[0];

  fma_unit #(
    .NumPipeRegs (NUM_REGS)
  ) u_dut (
    .clk_i       (clk),
    .arst_n_i    (arst_n),
    .flush_i     (flush),
    .req_i       (req),
    .in_valid_i  (in_valid),
    .in_ready_o  (in_ready),
    .rsp_o       (rsp),
    .out_valid_o (out_valid),
    .out_ready_i (out_ready),
    .busy_o      (busy)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------------------------
  // Expected queue, pushed on accept, popped on output
  // ------------------------------------------------
  always @(posedge clk) begin
    if (out_valid && out_ready && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
    end
    // Flush drops everything in flight, including this edge's input
    if (flush) begin
      exp_q.delete();
    end else if (in_valid && in_ready) begin
      exp_q.push_back(drive_exp);
    end
    exp_have  <= (exp_q.size() > 0);
    exp_count <= exp_q.size();
    if (exp_q.size() > 0) begin
      exp_head <= exp_q[0];
    end
  end

  // ------------------------------------------------
  // Output and handshake checkers
  // ------------------------------------------------
  a_rsp_match: assert property (@(posedge clk) disable iff (!arst_n)
    (out_valid && out_ready && exp_have) |-> (rsp == exp_head))
  else begin
    err_count++;
    $display("MISMATCH %s: expected %h/%b/%h actual %h/%b/%h", cur_test,
             $sampled(exp_head.result), $sampled(exp_head.status), $sampled(exp_head.tag),
             $sampled(rsp.result), $sampled(rsp.status), $sampled(rsp.tag));
  end

  // Nothing may leave the unit that was not accepted, e.g. after a flush
  a_no_extra: assert property (@(posedge clk) disable iff (!arst_n)
    (out_valid && out_ready) |-> exp_have)
  else begin
    err_count++;
    $display("ERROR %s: unexpected output item with tag %h", cur_test, $sampled(rsp.tag));
  end

  a_stall_hold: assert property (@(posedge clk) disable iff (!arst_n)
    (out_valid && !out_ready && !flush) |=> (out_valid && $stable(rsp)))
  else begin
    err_count++;
    $display("ERROR %s: output dropped or changed while stalled", cur_test);
  end

  a_flush_clear: assert property (@(posedge clk) disable iff (!arst_n)
    flush |=> (!out_valid && !busy))
  else begin
    err_count++;
    $display("ERROR %s: pipeline not empty after flush", cur_test);
  end

  // Busy exactly while accepted items are still inside
  a_busy_track: assert property (@(posedge clk) disable iff (!arst_n)
    busy == exp_have)
  else begin
    err_count++;
    $display("MISMATCH %s: busy expected %b actual %b", cur_test,
             $sampled(exp_have), $sampled(busy));
  end

  // A free register or a draining output lets a new item in
  a_in_ready: assert property (@(posedge clk) disable iff (!arst_n)
    in_ready == ((exp_count < NUM_REGS) || out_ready))
  else begin
    err_count++;
    $display("MISMATCH %s: in_ready expected %b actual %b", cur_test,
             $sampled((exp_count < NUM_REGS) || out_ready), $sampled(in_ready));
  end

  // ------------------------------------------------
  // Stimulus helpers, all return 1 ns after an edge
  // ------------------------------------------------
  task automatic note_timeout(input string what);
    timed_out = 1'b1;
    err_count++;
    $display("ERROR %s: %s did not complete within %0d cycles", cur_test, what, TIMEOUT);
  endtask

  task automatic load_req(input vec_t v, input logic [TAG_WIDTH-1:0] tag);
    req.operand_a = v.a;
    req.operand_b = v.b;
    req.operand_c = v.c;
    req.op        = v.op;
    req.op_mod    = v.op_mod;
    req.tag       = tag;
    drive_exp     = '{result: v.res, status: v.st, tag: tag};
  endtask

  // Holds the request until the unit takes it
  task automatic send_item(input vec_t v, input logic [TAG_WIDTH-1:0] tag);
    int cycles;
    if (timed_out) return;
    load_req(v, tag);
    in_valid = 1'b1;
    cycles   = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!in_ready && cycles <= TIMEOUT);
    #1;
    in_valid = 1'b0;
    if (cycles > TIMEOUT) note_timeout("input handshake");
  endtask

  task automatic run_vec(input logic [15:0] a, input logic [15:0] b, input logic [15:0] c,
                         input fma_op_e op, input logic op_mod, input logic [15:0] res,
                         input status_t st, input bit keep);
    vec_t v;
    v = '{a: a, b: b, c: c, op: op, op_mod: op_mod, res: res, st: st};
    if (keep) exact_q.push_back(v);
    send_item(v, TAG_WIDTH'(vec_count));
    vec_count++;
  endtask

  // Waits until every accepted item has left the unit
  task automatic drain(input string what);
    int cycles;
    cycles = 0;
    while (!timed_out && (exp_q.size() != 0 || busy)) begin
      @(posedge clk);
      #1;
      cycles++;
      if (cycles > TIMEOUT) note_timeout(what);
    end
  endtask

  task automatic start_test(input string name);
    cur_test    = name;
    errs_before = err_count;
  endtask

  task automatic end_test();
    test_count++;
    if (err_count != errs_before) begin
      test_fail++;
      $display("test %s: %0d errors", cur_test, err_count - errs_before);
    end else begin
      $display("test %s: ok", cur_test);
    end
  endtask

  // ------------------------------------------------
  // Tests
  // ------------------------------------------------
  task automatic idle_and_latency();
    int cycles;
    start_test("reset_latency");
    assert (!out_valid && !busy && in_ready) else begin
      err_count++;
      $display("ERROR %s: unit not idle after reset", cur_test);
    end
    ready_mode = 2'd1;
    // 1.5 * 2 + 0.25
    run_vec(16'h3E00, 16'h4000, 16'h3400, OP_FMADD, 1'b0, 16'h4280, ST_NONE, 1'b0);
    cycles = 0;
    while (!timed_out) begin
      @(posedge clk);
      cycles++;
      if (out_valid) break;
      if (cycles > TIMEOUT) note_timeout("lone item output");
    end
    #1;
    assert (cycles == NUM_REGS) else begin
      err_count++;
      $display("MISMATCH %s: expected latency %0d actual %0d", cur_test, NUM_REGS, cycles);
    end
    drain("latency drain");
    end_test();
  endtask

  task automatic exact_results();
    start_test("exact");
    ready_mode = 2'd1;
    run_vec(16'h3E00, 16'h4000, 16'h3400, OP_FMADD,  1'b0, 16'h4280, ST_NONE, 1'b1);
    run_vec(16'h3E00, 16'h4000, 16'h3400, OP_FMADD,  1'b1, 16'h4180, ST_NONE, 1'b1);
    run_vec(16'h3E00, 16'h4000, 16'h3400, OP_FNMSUB, 1'b0, 16'hC180, ST_NONE, 1'b1);
    run_vec(16'h3E00, 16'h4000, 16'h3400, OP_FNMSUB, 1'b1, 16'hC280, ST_NONE, 1'b1);
    // Operand A is replaced by +1.0 for ADD
    run_vec(16'h5555, 16'h4200, 16'h3400, OP_ADD,    1'b0, 16'h4280, ST_NONE, 1'b1);
    run_vec(16'h5555, 16'h4200, 16'h4200, OP_ADD,    1'b1, 16'h0000, ST_NONE, 1'b1);
    // Operand C is replaced by -0 for MUL
    run_vec(16'h3E00, 16'h4000, 16'h1234, OP_MUL,    1'b0, 16'h4200, ST_NONE, 1'b1);
    run_vec(16'h3E00, 16'hC000, 16'h1234, OP_MUL,    1'b1, 16'hC200, ST_NONE, 1'b1);
    run_vec(16'hBE00, 16'h0000, 16'h3C00, OP_MUL,    1'b0, 16'h8000, ST_NONE, 1'b1);
    // 9 - 1 and 3 - 3
    run_vec(16'h4200, 16'h4200, 16'hBC00, OP_FMADD,  1'b0, 16'h4800, ST_NONE, 1'b1);
    run_vec(16'h4200, 16'h3C00, 16'hC200, OP_FMADD,  1'b0, 16'h0000, ST_NONE, 1'b1);
    // Subnormal times two reaches the smallest normal
    run_vec(16'h0200, 16'h4000, 16'h0000, OP_FMADD,  1'b0, 16'h0400, ST_NONE, 1'b1);
    drain("exact drain");
    end_test();
  endtask

  task automatic rounding_flags();
    start_test("rounding");
    ready_mode = 2'd1;
    // Half an ulp above 1.0 ties to even
    run_vec(16'h5555, 16'h3C00, 16'h1000, OP_ADD, 1'b0, 16'h3C00, ST_NX, 1'b0);
    run_vec(16'h5555, 16'h3C00, 16'h1600, OP_ADD, 1'b0, 16'h3C02, ST_NX, 1'b0);
    run_vec(16'h5555, 16'h3C00, 16'h1001, OP_ADD, 1'b0, 16'h3C01, ST_NX, 1'b0);
    // Largest normal times two overflows
    run_vec(16'h7BFF, 16'h4000, 16'h0000, OP_MUL, 1'b0, 16'h7C00, ST_OF_NX, 1'b0);
    run_vec(16'h7BFF, 16'hC000, 16'h0000, OP_MUL, 1'b0, 16'hFC00, ST_OF_NX, 1'b0);
    // Tiny product rounds to the smallest subnormal
    run_vec(16'h0001, 16'h3C01, 16'h0000, OP_MUL, 1'b0, 16'h0001, ST_UF_NX, 1'b0);
    drain("rounding drain");
    end_test();
  endtask

  task automatic special_cases();
    start_test("special");
    ready_mode = 2'd1;
    run_vec(16'h7C00, 16'h0000, 16'h3C00, OP_FMADD,  1'b0, QNAN, ST_NV, 1'b0);
    // Inf times zero beats a quiet NaN addend
    run_vec(16'h0000, 16'hFC00, 16'h7E00, OP_FMADD,  1'b0, QNAN, ST_NV, 1'b0);
    run_vec(16'h7E00, 16'h3C00, 16'h3C00, OP_FMADD,  1'b0, QNAN, ST_NONE, 1'b0);
    run_vec(16'h3C00, 16'h3C00, 16'h7C01, OP_FMADD,  1'b0, QNAN, ST_NV, 1'b0);
    run_vec(16'h7C00, 16'h3C00, 16'hFC00, OP_FMADD,  1'b0, QNAN, ST_NV, 1'b0);
    run_vec(16'h7C00, 16'h3C00, 16'h7C00, OP_FMADD,  1'b1, QNAN, ST_NV, 1'b0);
    run_vec(16'h7C00, 16'hC000, 16'h3C00, OP_FMADD,  1'b0, 16'hFC00, ST_NONE, 1'b0);
    run_vec(16'h3C00, 16'h4000, 16'hFC00, OP_FMADD,  1'b0, 16'hFC00, ST_NONE, 1'b0);
    run_vec(16'h7C00, 16'h3C00, 16'h7C00, OP_FNMSUB, 1'b1, 16'hFC00, ST_NONE, 1'b0);
    run_vec(16'h7C00, 16'h7C00, 16'h0000, OP_MUL,    1'b0, 16'h7C00, ST_NONE, 1'b0);
    drain("special drain");
    end_test();
  endtask

  // Random table rows and tags under random back-pressure
  task automatic backpressure_burst();
    int   sent, guard;
    bit   accepted;
    vec_t v;
    start_test("burst");
    ready_mode = 2'd2;
    sent       = 0;
    guard      = 0;
    while (sent < BURST_LEN && !timed_out) begin
      if (!in_valid && $urandom_range(0, 3) != 0) begin
        v = exact_q[$urandom_range(0, exact_q.size() - 1)];
        load_req(v, TAG_WIDTH'($urandom_range(0, 15)));
        in_valid = 1'b1;
      end
      ready_rand = 1'($urandom_range(0, 1));
      @(posedge clk);
      // Ready seen at the edge decides the handshake
      accepted = in_valid && in_ready;
      #1;
      if (accepted) begin
        in_valid = 1'b0;
        sent++;
      end
      guard++;
      if (guard > BURST_LEN * 16) note_timeout("random burst");
    end
    in_valid   = 1'b0;
    ready_mode = 2'd1;
    drain("burst drain");
    end_test();
  endtask

  task automatic flush_in_flight();
    start_test("flush");
    ready_mode = 2'd0;
    send_item(exact_q[0], 4'hA);
    send_item(exact_q[1], 4'hB);
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
    // Both items were stalled at the output and must be gone
    assert (!out_valid && !busy) else begin
      err_count++;
      $display("ERROR %s: flushed items still in the unit", cur_test);
    end
    ready_mode = 2'd1;
    // The unit still works after the flush
    send_item(exact_q[2], 4'hC);
    drain("flush drain");
    end_test();
  endtask

  initial begin
    void'($urandom(SEED));
    arst_n     = 1'b0;
    flush      = 1'b0;
    in_valid   = 1'b0;
    req        = '0;
    drive_exp  = '0;
    ready_mode = 2'd0;
    ready_rand = 1'b0;
    cur_test   = "init";
    err_count  = 0;
    test_count = 0;
    test_fail  = 0;
    vec_count  = 0;
    timed_out  = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    arst_n = 1'b1;
    idle_and_latency();
    exact_results();
    rounding_flags();
    special_cases();
    backpressure_burst();
    flush_in_flight();
    $display("summary: %0d tests, %0d failed, %0d errors", test_count, test_fail, err_count);
    if (err_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: fma_unit.f
rtl/fma_pkg.sv
rtl/fma_classify_select.sv
rtl/fma_align_add.sv
rtl/fma_pipe_stage.sv
rtl/fma_normalize_round.sv
rtl/fma_unit.sv
tests/tb_fma_unit.sv

// File: Makefile
TOP := tb_fma_unit
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f fma_unit.f

obj_dir/V$(TOP): fma_unit.f $(wildcard rtl/*.sv) tests/tb_fma_unit.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f fma_unit.f

# Pass or fail comes from the log, not from the simulator exit code
sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
